// ==== Makefile ====
TOOL     := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := latency_scoreboard_tb
DUT_TOP  := latency_scoreboard
FLIST    := vlog.f
OBJ_DIR  := obj_dir
LOG      := sim.log
RUNFLAGS := +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	-./$(OBJ_DIR)/V$(TOP) $(RUNFLAGS) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then exit 1; fi
	@grep -q "Verification passed" $(LOG)

lint:
	$(TOOL) --lint-only -Wall --timing --top-module $(DUT_TOP) \
		verilog/latsb_pkg.sv verilog/sync_fifo.sv verilog/wrfence_gate.sv \
		verilog/latency_buffer.sv verilog/latency_scoreboard.sv

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim/latency_scoreboard_assert.sv ====
// Port-level assertions for the latency model top
// Reset values, error flags, and valid against occupancy
`timescale 1ns/1ps
`default_nettype none

module latency_scoreboard_assert (
   input wire logic        clk,
   input wire logic        rst,
   input wire logic        valid_i,
   input wire logic        full_i,
   input wire logic [15:0] count_i,
   input wire logic        overflow_i,
   input wire logic        underflow_i
);

   // Read by the testbench for its summary
   int fail_count = 0;

   // One cycle after a reset edge everything is idle
   property p_reset_values;
      @(posedge clk) rst |=> (!valid_i && !full_i && (count_i == 16'd0)
                              && !overflow_i && !underflow_i);
   endproperty

   // Source respects full, consumer respects valid
   property p_no_overflow;
      @(posedge clk) disable iff (rst) !overflow_i;
   endproperty

   property p_no_underflow;
      @(posedge clk) disable iff (rst) !underflow_i;
   endproperty

   // Empty design has no strobe in flight toward the output
   property p_valid_needs_count;
      @(posedge clk) disable iff (rst) (count_i == 16'd0) |=> !valid_i;
   endproperty

   a_reset_values: assert property (p_reset_values) else begin
      fail_count++;
      $error("outputs not idle after reset");
   end

   a_no_overflow: assert property (p_no_overflow) else begin
      fail_count++;
      $error("overflow_o raised");
   end

   a_no_underflow: assert property (p_no_underflow) else begin
      fail_count++;
      $error("underflow_o raised");
   end

   a_valid_needs_count: assert property (p_valid_needs_count) else begin
      fail_count++;
      $error("valid_o rose right after count_o was zero");
   end

endmodule

bind latency_scoreboard latency_scoreboard_assert u_assert (
   .clk         (clk),
   .rst         (rst),
   .valid_i     (valid_o),
   .full_i      (full_o),
   .count_i     (count_o),
   .overflow_i  (overflow_o),
   .underflow_i (underflow_o)
);

`default_nettype wire

// ==== sim/latency_scoreboard_tb.sv ====
// Testbench for the memory request latency model
// Random traffic, fence ordering, latency bounds and a full burst,
// against a model of outstanding payloads and fence epochs
`timescale 1ns/1ps
`default_nettype none

module latency_scoreboard_tb import latsb_pkg::*; ();

   localparam int N_RAND    = 40;
   localparam int N_LAT     = 12;
   localparam int N_FENCE   = 25;
   localparam int BURST_MAX = 64;
   // Cycle budget from the request count
   localparam int LIMIT = 200 * (N_RAND + N_LAT + N_FENCE + BURST_MAX) + 2000;

   logic              clk = 1'b0;
   logic              rst;
   logic              write_i;
   logic [META_W-1:0] meta_i;
   logic [DATA_W-1:0] data_i;
   logic              read_i;
   logic              full_o;
   logic [META_W-1:0] meta_o;
   logic [DATA_W-1:0] data_o;
   logic              valid_o;
   logic [15:0]       count_o;
   logic              overflow_o;
   logic              underflow_o;

   // Outstanding requests keyed by payload
   logic [META_W-1:0] exp_meta  [int unsigned];
   int                exp_cycle [int unsigned];
   int                exp_epoch [int unsigned];
   int                epoch_cnt [int];

   int          seed = 24640;
   int          cycles = 0;
   int          errors = 0;
   int          checks = 0;
   int          epoch = 0;
   int unsigned seq = 0;
   logic        read_en = 1'b0;

   latency_scoreboard u_dut (
      .clk         (clk),
      .rst         (rst),
      .write_i     (write_i),
      .meta_i      (meta_i),
      .data_i      (data_i),
      .full_o      (full_o),
      .meta_o      (meta_o),
      .data_o      (data_o),
      .valid_o     (valid_o),
      .read_i      (read_i),
      .count_o     (count_o),
      .overflow_o  (overflow_o),
      .underflow_o (underflow_o)
   );

   always #50 clk = !clk;

   // Cycle count doubles as timestamp
   always @(posedge clk) begin
      cycles++;
      if (cycles >= LIMIT) begin
         $display("Timeout after %0d cycles, %0d requests still outstanding",
                  cycles, exp_meta.num());
         $display("Verification failed");
         $finish;
      end
   end

   // Minimum delay of each request type
   function automatic int min_delay(input logic [META_W-1:0] m);
      case (m[META_W-1 -: TYPE_W])
         REQ_RDLINE: return int'(RDLINE_MIN);
         REQ_WRLINE: return int'(WRLINE_MIN);
         default:    return int'(WRTHRU_MIN);
      endcase
   endfunction

   // Random non-fence header
   function automatic logic [META_W-1:0] rand_meta();
      int                r;
      logic [TYPE_W-1:0] t;
      r = $random(seed);
      t = TYPE_W'((r & 32'h7fff_ffff) % 3);
      return {t, r[21:8]};
   endfunction

   // Compare one head against the model
   task automatic check_read();
      logic [DATA_W-1:0] d;
      logic [META_W-1:0] m;
      int                lat;
      int                oldest;
      d = data_o;
      m = meta_o;
      checks++;
      assert (m[META_W-1 -: TYPE_W] != REQ_WRFENCE) else begin
         $display("Fence header %h was read out at %0t", m, $time);
         errors++;
      end
      assert (exp_meta.exists(d)) else begin
         $display("Payload %0d read out at %0t was never written or came twice", d, $time);
         errors++;
      end
      if (exp_meta.exists(d)) begin
         assert (m == exp_meta[d]) else begin
            $display("CHECK FAILED at %0t: meta_o = %h, expected %h", $time, m, exp_meta[d]);
            errors++;
         end
         lat = cycles - exp_cycle[d];
         assert (lat >= min_delay(exp_meta[d]) + 4) else begin
            $display("Payload %0d left after %0d cycles, minimum is %0d",
                     d, lat, min_delay(exp_meta[d]) + 4);
            errors++;
         end
         // Oldest epoch with requests still out
         void'(epoch_cnt.first(oldest));
         assert (exp_epoch[d] == oldest) else begin
            $display("Payload %0d of fence epoch %0d overtook epoch %0d at %0t",
                     d, exp_epoch[d], oldest, $time);
            errors++;
         end
         epoch_cnt[exp_epoch[d]]--;
         if (epoch_cnt[exp_epoch[d]] == 0) begin
            epoch_cnt.delete(exp_epoch[d]);
         end
         exp_meta.delete(d);
         exp_cycle.delete(d);
         exp_epoch.delete(d);
      end
   endtask

   // One clock, inputs driven just after the edge
   task automatic step(input logic wr, input logic [META_W-1:0] m);
      @(posedge clk);
      #1;
      write_i = wr;
      meta_i  = m;
      data_i  = seq;
      read_i  = 1'b0;
      if (wr) begin
         if (m[META_W-1 -: TYPE_W] == REQ_WRFENCE) begin
            epoch++;
         end else begin
            exp_meta[seq]  = m;
            exp_cycle[seq] = cycles;
            exp_epoch[seq] = epoch;
            if (!epoch_cnt.exists(epoch)) begin
               epoch_cnt[epoch] = 0;
            end
            epoch_cnt[epoch]++;
         end
         seq++;
      end
      if (read_en && valid_o) begin
         read_i = 1'b1;
         check_read();
      end
   endtask

   // Write once the input has room
   task automatic send(input logic [META_W-1:0] m);
      while (full_o) begin
         step(1'b0, '0);
      end
      step(1'b1, m);
   endtask

   task automatic drain();
      while (exp_meta.num() != 0) begin
         step(1'b0, '0);
      end
   endtask

   task automatic report(input string name, input int err_before);
      $display("Test %s: %0d errors", name, errors - err_before);
   endtask

   initial begin
      int e0;
      int n;
      int total;
      rst     = 1'b1;
      write_i = 1'b0;
      meta_i  = '0;
      data_i  = '0;
      read_i  = 1'b0;
      repeat (3) @(posedge clk);
      #1;
      rst = 1'b0;

      // Idle outputs after reset
      e0 = errors;
      checks += 3;
      assert (valid_o == 1'b0) else begin
         $display("CHECK FAILED at %0t: valid_o = %b, expected 0", $time, valid_o);
         errors++;
      end
      assert (full_o == 1'b0) else begin
         $display("CHECK FAILED at %0t: full_o = %b, expected 0", $time, full_o);
         errors++;
      end
      assert (count_o == 16'd0) else begin
         $display("CHECK FAILED at %0t: count_o = %0d, expected 0", $time, count_o);
         errors++;
      end
      report("reset values", e0);

      // Mixed traffic, any order
      e0 = errors;
      read_en = 1'b1;
      for (int i = 0; i < N_RAND; i++) begin
         send(rand_meta());
      end
      drain();
      report("random traffic", e0);

      // Types in rotation for the delay bounds
      e0 = errors;
      for (int i = 0; i < N_LAT; i++) begin
         send({TYPE_W'(i % 3), 14'(i)});
      end
      drain();
      report("latency bounds", e0);

      // Two fences split the stream into three epochs
      e0 = errors;
      for (int i = 0; i < N_FENCE; i++) begin
         if (i == 10 || i == 20) begin
            send({REQ_WRFENCE, 14'h0});
         end
         send(rand_meta());
      end
      drain();
      report("fence ordering", e0);

      // Fill with the consumer stalled
      e0 = errors;
      read_en = 1'b0;
      n = 0;
      while (!full_o && n < BURST_MAX) begin
         step(1'b1, rand_meta());
         n++;
      end
      // Burst is longer than the whole design can hold
      checks++;
      assert (full_o == 1'b1) else begin
         $display("CHECK FAILED at %0t: full_o = %b, expected 1", $time, full_o);
         errors++;
      end
      repeat (100) step(1'b0, '0);
      checks++;
      assert (count_o == 16'(exp_meta.num())) else begin
         $display("CHECK FAILED at %0t: count_o = %0d, expected %0d",
                  $time, count_o, exp_meta.num());
         errors++;
      end
      read_en = 1'b1;
      drain();
      repeat (5) step(1'b0, '0);
      report("full burst", e0);

      total = errors + u_dut.u_assert.fail_count;
      $display("Summary: 5 tests, %0d checks, %0d errors, %0d assertion failures",
               checks, errors, u_dut.u_assert.fail_count);
      if (total == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog/latency_buffer.sv ====
// Latency buffer with per-slot countdown
// Loads requests into the lowest free slot with an LFSR-drawn delay per type,
// releases expired slots round-robin toward the output FIFO
`timescale 1ns/1ps
`default_nettype none

module latency_buffer import latsb_pkg::*; #(
   parameter int          NUM_SLOTS = 8,
   parameter logic [15:0] LFSR_SEED = 16'hACE1
) (
   input  logic              clk,
   input  logic              rst,
   // Request queue head
   input  logic              q_valid_i,
   input  logic [META_W-1:0] q_meta_i,
   input  logic [DATA_W-1:0] q_data_i,
   output logic              q_pop_o,
   // Output FIFO write side
   input  logic              out_alm_full_i,
   output logic              out_wr_o,
   output logic [META_W-1:0] out_meta_o,
   output logic [DATA_W-1:0] out_data_o,
   // Status
   output logic [7:0]        occupancy_o,
   output logic              buf_empty_o
);

   localparam int IDX_W = (NUM_SLOTS > 1) ? $clog2(NUM_SLOTS) : 1;

   // Slot states
   localparam logic [1:0] S_FREE  = 2'd0;
   localparam logic [1:0] S_COUNT = 2'd1;
   localparam logic [1:0] S_READY = 2'd2;
   localparam logic [1:0] S_LEAVE = 2'd3;

   // Range widths, bounds inclusive
   localparam int RD_SPAN = int'(RDLINE_MAX - RDLINE_MIN) + 1;
   localparam int WL_SPAN = int'(WRLINE_MAX - WRLINE_MIN) + 1;
   localparam int WT_SPAN = int'(WRTHRU_MAX - WRTHRU_MIN) + 1;

   logic [1:0]           slot_state [NUM_SLOTS];
   logic [CTR_W-1:0]     slot_ctr   [NUM_SLOTS];
   logic [META_W-1:0]    slot_meta  [NUM_SLOTS];
   logic [DATA_W-1:0]    slot_data  [NUM_SLOTS];

   // Staging between pop and slot load
   logic                 ld_pend;
   logic [IDX_W-1:0]     ld_slot;
   logic [META_W-1:0]    ld_meta;
   logic [DATA_W-1:0]    ld_data;
   logic [CTR_W-1:0]     ld_delay;

   logic [15:0]          lfsr;
   logic [NUM_SLOTS-1:0] free_vec;
   logic [NUM_SLOTS-1:0] ready_vec;
   logic                 free_found;
   logic [IDX_W-1:0]     free_idx;
   logic                 rel_found;
   logic [IDX_W-1:0]     rel_idx;
   logic                 rel_go;
   logic [IDX_W-1:0]     rr_ptr;
   logic [7:0]           occ;
   logic                 alm_full;

   // Free-running LFSR, taps 16 14 13 11
   always_ff @(posedge clk) begin
      if (rst) begin
         lfsr <= LFSR_SEED;
      end else begin
         lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
      end
   end

   // Delay drawn in the load cycle
   always_comb begin
      case (req_type_t'(ld_meta[META_W-1 -: TYPE_W]))
         REQ_RDLINE: ld_delay = RDLINE_MIN + CTR_W'(lfsr % 16'(RD_SPAN));
         REQ_WRLINE: ld_delay = WRLINE_MIN + CTR_W'(lfsr % 16'(WL_SPAN));
         REQ_WRTHRU: ld_delay = WRTHRU_MIN + CTR_W'(lfsr % 16'(WT_SPAN));
         // Fences stop at the gate
         default:    ld_delay = '0;
      endcase
   end

   // A slot awaiting its load is not free
   always_comb begin
      for (int i = 0; i < NUM_SLOTS; i++) begin
         free_vec[i]  = (slot_state[i] == S_FREE) && !(ld_pend && (ld_slot == IDX_W'(i)));
         ready_vec[i] = (slot_state[i] == S_READY);
      end
   end

   // Lowest free slot wins
   always_comb begin
      free_found = 1'b0;
      free_idx   = '0;
      for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
         if (free_vec[i]) begin
            free_found = 1'b1;
            free_idx   = IDX_W'(i);
         end
      end
   end

   // Round-robin search from rr_ptr
   always_comb begin
      int idx;
      rel_found = 1'b0;
      rel_idx   = '0;
      for (int i = 0; i < NUM_SLOTS; i++) begin
         idx = (int'(rr_ptr) + i) % NUM_SLOTS;
         if (!rel_found && ready_vec[idx]) begin
            rel_found = 1'b1;
            rel_idx   = IDX_W'(idx);
         end
      end
   end

   // Used slots plus the load in flight
   always_comb begin
      occ = {7'd0, ld_pend};
      for (int i = 0; i < NUM_SLOTS; i++) begin
         if (slot_state[i] != S_FREE) begin
            occ = occ + 8'd1;
         end
      end
   end

   assign alm_full    = (occ >= 8'(NUM_SLOTS - 1));
   assign q_pop_o     = q_valid_i && free_found && !alm_full;
   assign rel_go      = rel_found && !out_alm_full_i;
   assign occupancy_o = occ;
   assign buf_empty_o = (occ == 8'd0);

   // Pop stage
   always_ff @(posedge clk) begin
      if (rst) begin
         ld_pend <= 1'b0;
      end else begin
         ld_pend <= q_pop_o;
      end
   end

   always_ff @(posedge clk) begin
      if (q_pop_o) begin
         ld_slot <= free_idx;
         ld_meta <= q_meta_i;
         ld_data <= q_data_i;
      end
   end

   // Per-slot FSM, counting lasts delay plus one cycle
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < NUM_SLOTS; i++) begin
            slot_state[i] <= S_FREE;
         end
      end else begin
         for (int i = 0; i < NUM_SLOTS; i++) begin
            case (slot_state[i])
               S_FREE:  if (ld_pend && (ld_slot == IDX_W'(i))) slot_state[i] <= S_COUNT;
               S_COUNT: if (slot_ctr[i] == '0) slot_state[i] <= S_READY;
               S_READY: if (rel_go && (rel_idx == IDX_W'(i))) slot_state[i] <= S_LEAVE;
               // Leaving frees as the strobe lands in the output FIFO
               default: slot_state[i] <= S_FREE;
            endcase
         end
      end
   end

   // Slot contents and countdown
   always_ff @(posedge clk) begin
      for (int i = 0; i < NUM_SLOTS; i++) begin
         if (ld_pend && (ld_slot == IDX_W'(i)) && (slot_state[i] == S_FREE)) begin
            slot_meta[i] <= ld_meta;
            slot_data[i] <= ld_data;
            slot_ctr[i]  <= ld_delay;
         end else if ((slot_state[i] == S_COUNT) && (slot_ctr[i] != '0)) begin
            slot_ctr[i] <= slot_ctr[i] - 1'b1;
         end
      end
   end

   // Registered release strobe
   always_ff @(posedge clk) begin
      if (rst) begin
         out_wr_o <= 1'b0;
         rr_ptr   <= '0;
      end else begin
         out_wr_o <= rel_go;
         if (rel_go) begin
            rr_ptr <= (rel_idx == IDX_W'(NUM_SLOTS - 1)) ? '0 : rel_idx + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rel_go) begin
         out_meta_o <= slot_meta[rel_idx];
         out_data_o <= slot_data[rel_idx];
      end
   end

endmodule

`default_nettype wire

// ==== verilog/latency_scoreboard.sv ====
// Memory request latency model, top level
// Input FIFO, fence gate, filtered request queue, latency buffer, output FIFO
`timescale 1ns/1ps
`default_nettype none

module latency_scoreboard import latsb_pkg::*; #(
   parameter int          NUM_SLOTS       = 8,
   parameter int          IN_DEPTH_LOG2   = 5,
   parameter int          Q_DEPTH_LOG2    = 3,
   parameter int          OUT_DEPTH_LOG2  = 3,
   parameter int          IN_FULL_THRESH  = 24,
   parameter int          Q_FULL_THRESH   = 6,
   parameter int          OUT_FULL_THRESH = 6,
   parameter logic [15:0] LFSR_SEED       = 16'hACE1
) (
   input  logic              clk,
   input  logic              rst,
   // Request in, single-cycle strobe
   input  logic              write_i,
   input  logic [META_W-1:0] meta_i,
   input  logic [DATA_W-1:0] data_i,
   output logic              full_o,
   // Request out, head valid while valid_o
   output logic [META_W-1:0] meta_o,
   output logic [DATA_W-1:0] data_o,
   output logic              valid_o,
   input  logic              read_i,
   // Status
   output logic [15:0]       count_o,
   output logic              overflow_o,
   underflow_o
);

   localparam int FIFO_W = META_W + DATA_W;

   // Input stage
   logic [META_W-1:0]       in_meta;
   logic [DATA_W-1:0]       in_data;
   logic                    in_valid;
   logic                    in_pop;
   logic [IN_DEPTH_LOG2:0]  in_count;
   logic                    in_ovf;
   logic                    in_unf;

   // Fence-filtered queue
   logic                    q_push;
   logic [META_W-1:0]       q_push_meta;
   logic [DATA_W-1:0]       q_push_data;
   logic [META_W-1:0]       q_meta;
   logic [DATA_W-1:0]       q_data;
   logic                    q_valid;
   logic                    q_pop;
   logic                    q_alm_full;
   logic                    q_empty;
   logic [Q_DEPTH_LOG2:0]   q_count;
   logic                    q_ovf;
   logic                    q_unf;

   // Output stage
   logic                    out_wr;
   logic [META_W-1:0]       out_wr_meta;
   logic [DATA_W-1:0]       out_wr_data;
   logic                    out_alm_full;
   logic                    out_empty;
   logic [OUT_DEPTH_LOG2:0] out_count;
   logic                    out_ovf;
   logic                    out_unf;

   logic [7:0]              occupancy;
   logic                    buf_empty;
   logic                    drain_done;

   // Source must stop at almost-full
   sync_fifo #(
      .WIDTH       (FIFO_W),
      .DEPTH_LOG2  (IN_DEPTH_LOG2),
      .FULL_THRESH (IN_FULL_THRESH)
   ) u_in_fifo (
      .clk         (clk),
      .rst         (rst),
      .wr_en_i     (write_i),
      .din_i       ({meta_i, data_i}),
      .rd_en_i     (in_pop),
      .dout_o      ({in_meta, in_data}),
      .valid_o     (in_valid),
      .alm_full_o  (full_o),
      .empty_o     (),
      .count_o     (in_count),
      .overflow_o  (in_ovf),
      .underflow_o (in_unf)
   );

   // Everything older than a fence has left the design
   assign drain_done = q_empty && buf_empty && out_empty;

   wrfence_gate u_wrfence_gate (
      .clk          (clk),
      .rst          (rst),
      .in_valid_i   (in_valid),
      .in_meta_i    (in_meta),
      .in_data_i    (in_data),
      .q_alm_full_i (q_alm_full),
      .drain_done_i (drain_done),
      .in_pop_o     (in_pop),
      .q_push_o     (q_push),
      .q_meta_o     (q_push_meta),
      .q_data_o     (q_push_data)
   );

   sync_fifo #(
      .WIDTH       (FIFO_W),
      .DEPTH_LOG2  (Q_DEPTH_LOG2),
      .FULL_THRESH (Q_FULL_THRESH)
   ) u_q_fifo (
      .clk         (clk),
      .rst         (rst),
      .wr_en_i     (q_push),
      .din_i       ({q_push_meta, q_push_data}),
      .rd_en_i     (q_pop),
      .dout_o      ({q_meta, q_data}),
      .valid_o     (q_valid),
      .alm_full_o  (q_alm_full),
      .empty_o     (q_empty),
      .count_o     (q_count),
      .overflow_o  (q_ovf),
      .underflow_o (q_unf)
   );

   latency_buffer #(
      .NUM_SLOTS (NUM_SLOTS),
      .LFSR_SEED (LFSR_SEED)
   ) u_latency_buffer (
      .clk            (clk),
      .rst            (rst),
      .q_valid_i      (q_valid),
      .q_meta_i       (q_meta),
      .q_data_i       (q_data),
      .q_pop_o        (q_pop),
      .out_alm_full_i (out_alm_full),
      .out_wr_o       (out_wr),
      .out_meta_o     (out_wr_meta),
      .out_data_o     (out_wr_data),
      .occupancy_o    (occupancy),
      .buf_empty_o    (buf_empty)
   );

   // Read side faces the consumer directly
   sync_fifo #(
      .WIDTH       (FIFO_W),
      .DEPTH_LOG2  (OUT_DEPTH_LOG2),
      .FULL_THRESH (OUT_FULL_THRESH)
   ) u_out_fifo (
      .clk         (clk),
      .rst         (rst),
      .wr_en_i     (out_wr),
      .din_i       ({out_wr_meta, out_wr_data}),
      .rd_en_i     (read_i),
      .dout_o      ({meta_o, data_o}),
      .valid_o     (valid_o),
      .alm_full_o  (out_alm_full),
      .empty_o     (out_empty),
      .count_o     (out_count),
      .overflow_o  (out_ovf),
      .underflow_o (out_unf)
   );

   // Requests held anywhere in the design
   assign count_o = 16'(in_count) + 16'(q_count) + 16'(occupancy) + 16'(out_count);

   assign overflow_o  = in_ovf || q_ovf || out_ovf;
   assign underflow_o = in_unf || q_unf || out_unf;

endmodule

`default_nettype wire

// ==== verilog/latsb_pkg.sv ====
// Latency model shared definitions
// Header layout, request-type codes and per-type delay ranges
`default_nettype none

package latsb_pkg;

   // Header and payload widths
   localparam int META_W = 16;
   localparam int DATA_W = 32;

   // Type field sits in the top bits of the header
   localparam int TYPE_W = 2;

   // Countdown counter width per slot
   localparam int CTR_W = 8;

   // Request type codes
   typedef enum logic [TYPE_W-1:0] {
      REQ_RDLINE  = 2'b00,
      REQ_WRLINE  = 2'b01,
      REQ_WRTHRU  = 2'b10,
      REQ_WRFENCE = 2'b11
   } req_type_t;

   // Read line delay bounds, inclusive
   localparam logic [CTR_W-1:0] RDLINE_MIN = 8'd8;
   localparam logic [CTR_W-1:0] RDLINE_MAX = 8'd40;

   // Write line delay bounds
   localparam logic [CTR_W-1:0] WRLINE_MIN = 8'd4;
   localparam logic [CTR_W-1:0] WRLINE_MAX = 8'd20;

   // Write-through delay bounds
   localparam logic [CTR_W-1:0] WRTHRU_MIN = 8'd2;
   localparam logic [CTR_W-1:0] WRTHRU_MAX = 8'd10;

   // Fences carry no range, they never reach the slot array

endpackage

`default_nettype wire

// ==== verilog/sync_fifo.sv ====
// Synchronous FIFO, first word falls through to the head
// Occupancy count, almost-full threshold, overflow and underflow pulses
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
   parameter int WIDTH       = 32,
   parameter int DEPTH_LOG2  = 3,
   parameter int FULL_THRESH = 6
) (
   input  logic                  clk,
   input  logic                  rst,
   // Write side
   input  logic                  wr_en_i,
   input  logic [WIDTH-1:0]      din_i,
   // Read side, head shown while valid
   input  logic                  rd_en_i,
   output logic [WIDTH-1:0]      dout_o,
   output logic                  valid_o,
   // Status
   output logic                  alm_full_o,
   output logic                  empty_o,
   output logic [DEPTH_LOG2:0]   count_o,
   output logic                  overflow_o,
   output logic                  underflow_o
);

   localparam int DEPTH = 1 << DEPTH_LOG2;
   localparam logic [DEPTH_LOG2:0] FULL_CNT = (DEPTH_LOG2 + 1)'(DEPTH);
   localparam logic [DEPTH_LOG2:0] THRESH   = (DEPTH_LOG2 + 1)'(FULL_THRESH);

   logic [WIDTH-1:0]      mem [DEPTH];
   logic [DEPTH_LOG2-1:0] wr_ptr;
   logic [DEPTH_LOG2-1:0] rd_ptr;
   logic [DEPTH_LOG2:0]   count;
   logic                  full;
   logic                  empty;
   logic                  do_wr;
   logic                  do_rd;

   assign full  = (count == FULL_CNT);
   assign empty = (count == '0);

   // Illegal accesses are dropped
   assign do_wr = wr_en_i && !full;
   assign do_rd = rd_en_i && !empty;

   // Storage array
   always_ff @(posedge clk) begin
      if (do_wr) begin
         mem[wr_ptr] <= din_i;
      end
   end

   // Pointers, count and error pulses
   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr      <= '0;
         rd_ptr      <= '0;
         count       <= '0;
         overflow_o  <= 1'b0;
         underflow_o <= 1'b0;
      end else begin
         if (do_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         overflow_o  <= wr_en_i && full;
         underflow_o <= rd_en_i && empty;
      end
   end

   // Head is combinational
   assign dout_o     = mem[rd_ptr];
   assign valid_o    = !empty;
   assign empty_o    = empty;
   assign alm_full_o = (count >= THRESH);
   assign count_o    = count;

endmodule

`default_nettype wire

// ==== verilog/wrfence_gate.sv ====
// Write fence gate between the input FIFO and the request queue
// Forwards ordinary requests, traps a fence until everything older has drained
`timescale 1ns/1ps
`default_nettype none

module wrfence_gate import latsb_pkg::*; (
   input  logic              clk,
   input  logic              rst,
   // Input FIFO head
   input  logic              in_valid_i,
   input  logic [META_W-1:0] in_meta_i,
   input  logic [DATA_W-1:0] in_data_i,
   // Downstream status
   input  logic              q_alm_full_i,
   input  logic              drain_done_i,
   output logic              in_pop_o,
   // Filtered push into the request queue
   output logic              q_push_o,
   output logic [META_W-1:0] q_meta_o,
   output logic [DATA_W-1:0] q_data_o
);

   localparam logic [1:0] ST_PASS    = 2'd0;
   localparam logic [1:0] ST_WAIT    = 2'd1;
   localparam logic [1:0] ST_RELEASE = 2'd2;

   logic [1:0] state;
   logic [1:0] state_nxt;
   req_type_t  head_type;
   logic       head_fence;
   logic       fwd_pop;

   // Type field of the head
   assign head_type  = req_type_t'(in_meta_i[META_W-1 -: TYPE_W]);
   assign head_fence = in_valid_i && (head_type == REQ_WRFENCE);

   // Ordinary heads pass while the queue has room
   assign fwd_pop  = (state == ST_PASS) && in_valid_i && !head_fence && !q_alm_full_i;
   // Fence leaves once, in the release cycle
   assign in_pop_o = fwd_pop || ((state == ST_RELEASE) && head_fence);

   always_comb begin
      state_nxt = state;
      case (state)
         ST_PASS: if (head_fence) state_nxt = ST_WAIT;
         ST_WAIT: if (drain_done_i) state_nxt = ST_RELEASE;
         // Release lasts one cycle
         default: state_nxt = ST_PASS;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state    <= ST_PASS;
         q_push_o <= 1'b0;
      end else begin
         state    <= state_nxt;
         q_push_o <= fwd_pop;
      end
   end

   // Forwarded request, one cycle behind its pop
   always_ff @(posedge clk) begin
      if (fwd_pop) begin
         q_meta_o <= in_meta_i;
         q_data_o <= in_data_i;
      end
   end

endmodule

`default_nettype wire

// ==== vlog.f ====
verilog/latsb_pkg.sv
verilog/sync_fifo.sv
verilog/wrfence_gate.sv
verilog/latency_buffer.sv
verilog/latency_scoreboard.sv
sim/latency_scoreboard_assert.sv
sim/latency_scoreboard_tb.sv
